/* common/vsys_cfg.svh */
/* Store path configuration
   Address, data and cache line sizes shared by the whole design */

`ifndef VSYS_CFG_SVH
`define VSYS_CFG_SVH

// Byte address width
`define VSYS_ADDR_W 32

// Scalar core store width
`define VSYS_NARROW_W 32

// Accelerator and system port width
`define VSYS_WIDE_W 64

// Scalar data cache line size in bytes
`define VSYS_LINE_BYTES 16

`endif

/* common/vsys_pkg.sv */
/* Store path types
   Request structs for the scalar, wide and system ports */

`include "vsys_cfg.svh"

package vsys_pkg;

  // One scalar store
  typedef struct packed {
    logic [`VSYS_ADDR_W-1:0]     addr;
    logic [`VSYS_NARROW_W-1:0]   data;
    logic [`VSYS_NARROW_W/8-1:0] strb;
  } narrow_req_t;

  // One wide store, address aligned to the wide word
  typedef struct packed {
    logic [`VSYS_ADDR_W-1:0]   addr;
    logic [`VSYS_WIDE_W-1:0]   data;
    logic [`VSYS_WIDE_W/8-1:0] strb;
  } wide_req_t;

  // Request source tag
  typedef enum logic {
    SRC_SCALAR = 1'b0,
    SRC_ACCEL  = 1'b1
  } src_e;

  // System port request
  typedef struct packed {
    wide_req_t req;
    src_e      src;
  } sys_req_t;

endpackage

/* verilog/pipe_reg.sv */
/* Pipeline register
   Single-entry valid/ready slice holding any payload type */

`timescale 1ns/1ps

module pipe_reg #(
  parameter type data_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  data_t in_data_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output data_t out_data_o,
  output logic  out_valid_o,
  input  logic  out_ready_i
);

  logic  full_q;
  data_t data_q;

  // Free slot, or the held entry leaves this cycle
  assign in_ready_o = !full_q || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (in_ready_o) begin
      full_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_data_o  = data_q;
  assign out_valid_o = full_q;

endmodule

/* verilog/store_upsizer.sv */
/* Store upsizer
   Widens a scalar store onto its lane of the wide data word */

`timescale 1ns/1ps

`include "vsys_cfg.svh"

module store_upsizer import vsys_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  narrow_req_t req_i,
  input  logic        valid_i,
  output logic        ready_o,
  output wide_req_t   req_o,
  output logic        valid_o,
  input  logic        ready_i
);

  localparam int unsigned NARROW_BYTES = `VSYS_NARROW_W / 8;
  localparam int unsigned WIDE_BYTES   = `VSYS_WIDE_W / 8;
  localparam int unsigned LANE_W       = $clog2(WIDE_BYTES / NARROW_BYTES);
  localparam int unsigned LANE_LSB     = $clog2(NARROW_BYTES);

  logic [LANE_W-1:0] lane;
  wide_req_t         wide_req;

  // Lane select comes from the address bits above the narrow word
  assign lane = req_i.addr[LANE_LSB +: LANE_W];

  always_comb begin
    wide_req.addr = req_i.addr & ~(`VSYS_ADDR_W'(WIDE_BYTES - 1));
    wide_req.data = `VSYS_WIDE_W'(req_i.data) << (lane * `VSYS_NARROW_W);
    wide_req.strb = WIDE_BYTES'(req_i.strb) << (lane * NARROW_BYTES);
  end

  pipe_reg #(
    .data_t      (wide_req_t)
  ) i_out_reg (
    .clk_i       (clk_i     ),
    .rst_i       (rst_i     ),
    .in_data_i   (wide_req  ),
    .in_valid_i  (valid_i   ),
    .in_ready_o  (ready_o   ),
    .out_data_o  (req_o     ),
    .out_valid_o (valid_o   ),
    .out_ready_i (ready_i   )
  );

endmodule

/* verilog/inval_filter.sv */
/* Invalidation filter
   Holds one accelerator store and reports its cache line to the scalar core */

`timescale 1ns/1ps

`include "vsys_cfg.svh"

module inval_filter import vsys_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    cons_en_i,
  input  wide_req_t               req_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output wide_req_t               req_o,
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic [`VSYS_ADDR_W-1:0] inval_addr_o,
  output logic                    inval_valid_o,
  input  logic                    inval_ready_i
);

  localparam int unsigned LINE_OFF = $clog2(`VSYS_LINE_BYTES);

  wide_req_t               req_q;
  logic                    req_pend_q;
  logic                    inv_pend_q;
  logic                    line_vld_q;
  logic [`VSYS_ADDR_W-1:0] line_q;
  logic [`VSYS_ADDR_W-1:0] line_addr;
  logic                    accept;
  logic                    inv_due;

  // Next store waits until both the store and its invalidation are gone
  assign ready_o = !req_pend_q && !inv_pend_q;
  assign accept  = valid_i && ready_o;

  assign line_addr = {req_i.addr[`VSYS_ADDR_W-1:LINE_OFF], {LINE_OFF{1'b0}}};
  assign inv_due   = cons_en_i && (|req_i.strb) && (!line_vld_q || line_addr != line_q);

  ////////////////////////////////////////////////////////////
  // Pending flags and remembered line
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_pend_q <= 1'b0;
      inv_pend_q <= 1'b0;
      line_vld_q <= 1'b0;
    end else begin
      if (valid_o && ready_i) begin
        req_pend_q <= 1'b0;
      end
      if (inval_valid_o && inval_ready_i) begin
        inv_pend_q <= 1'b0;
      end
      if (accept) begin
        req_pend_q <= 1'b1;
        inv_pend_q <= inv_due;
      end
      // Consistency off forgets the line
      if (!cons_en_i) begin
        line_vld_q <= 1'b0;
      end else if (accept && inv_due) begin
        line_vld_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (accept && inv_due) begin
      line_q <= line_addr;
    end
  end

  assign req_o         = req_q;
  assign valid_o       = req_pend_q;
  assign inval_addr_o  = line_q;
  assign inval_valid_o = inv_pend_q;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_inval_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    inval_valid_o && !inval_ready_i |=> inval_valid_o && $stable(inval_addr_o));

  // Output only starts one cycle after an accepted store
  a_valid_src: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(valid_o) |-> $past(valid_i && ready_o));

endmodule

/* verilog/store_arbiter.sv */
/* Store arbiter
   Round-robin merge of scalar and accelerator stores onto the system port */

`timescale 1ns/1ps

module store_arbiter import vsys_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  wide_req_t scalar_req_i,
  input  logic      scalar_valid_i,
  output logic      scalar_ready_o,
  input  wide_req_t acc_req_i,
  input  logic      acc_valid_i,
  output logic      acc_ready_o,
  output sys_req_t  mem_req_o,
  output logic      mem_valid_o,
  input  logic      mem_ready_i
);

  src_e     rr_q;
  src_e     sel;
  sys_req_t arb_req;
  logic     arb_valid;
  logic     arb_ready;
  logic     gnt_scalar;
  logic     gnt_acc;

  // Pointer only matters when both sides request
  always_comb begin
    if (scalar_valid_i && acc_valid_i) begin
      sel = rr_q;
    end else if (acc_valid_i) begin
      sel = SRC_ACCEL;
    end else begin
      sel = SRC_SCALAR;
    end
  end

  assign arb_valid      = scalar_valid_i || acc_valid_i;
  assign arb_req.req    = (sel == SRC_ACCEL) ? acc_req_i : scalar_req_i;
  assign arb_req.src    = sel;
  assign scalar_ready_o = arb_ready && (sel == SRC_SCALAR);
  assign acc_ready_o    = arb_ready && (sel == SRC_ACCEL);
  assign gnt_scalar     = scalar_valid_i && scalar_ready_o;
  assign gnt_acc        = acc_valid_i && acc_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q <= SRC_SCALAR;
    end else if (gnt_scalar || gnt_acc) begin
      rr_q <= (sel == SRC_SCALAR) ? SRC_ACCEL : SRC_SCALAR;
    end
  end

  pipe_reg #(
    .data_t      (sys_req_t  )
  ) i_mem_reg (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .in_data_i   (arb_req    ),
    .in_valid_i  (arb_valid  ),
    .in_ready_o  (arb_ready  ),
    .out_data_o  (mem_req_o  ),
    .out_valid_o (mem_valid_o),
    .out_ready_i (mem_ready_i)
  );

  // A waiting input is never passed over twice in a row
  a_rr_fair_acc: assert property (@(posedge clk_i) disable iff (rst_i)
    gnt_scalar && acc_valid_i |=> !gnt_scalar);

  a_rr_fair_scalar: assert property (@(posedge clk_i) disable iff (rst_i)
    gnt_acc && scalar_valid_i |=> !gnt_acc);

endmodule

/* verilog/vsys_top.sv */
/* Store path top
   Scalar upsizer and accelerator filter merged onto one system port */

`timescale 1ns/1ps

`include "vsys_cfg.svh"

module vsys_top import vsys_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    cons_en_i,
  input  narrow_req_t             scalar_req_i,
  input  logic                    scalar_valid_i,
  output logic                    scalar_ready_o,
  input  wide_req_t               acc_req_i,
  input  logic                    acc_valid_i,
  output logic                    acc_ready_o,
  output sys_req_t                mem_req_o,
  output logic                    mem_valid_o,
  input  logic                    mem_ready_i,
  output logic [`VSYS_ADDR_W-1:0] inval_addr_o,
  output logic                    inval_valid_o,
  input  logic                    inval_ready_i
);

  wide_req_t up_req;
  logic      up_valid;
  logic      up_ready;
  wide_req_t flt_req;
  logic      flt_valid;
  logic      flt_ready;

  store_upsizer i_upsizer (
    .clk_i   (clk_i         ),
    .rst_i   (rst_i         ),
    .req_i   (scalar_req_i  ),
    .valid_i (scalar_valid_i),
    .ready_o (scalar_ready_o),
    .req_o   (up_req        ),
    .valid_o (up_valid      ),
    .ready_i (up_ready      )
  );

  inval_filter i_filter (
    .clk_i         (clk_i        ),
    .rst_i         (rst_i        ),
    .cons_en_i     (cons_en_i    ),
    .req_i         (acc_req_i    ),
    .valid_i       (acc_valid_i  ),
    .ready_o       (acc_ready_o  ),
    .req_o         (flt_req      ),
    .valid_o       (flt_valid    ),
    .ready_i       (flt_ready    ),
    .inval_addr_o  (inval_addr_o ),
    .inval_valid_o (inval_valid_o),
    .inval_ready_i (inval_ready_i)
  );

  store_arbiter i_arbiter (
    .clk_i          (clk_i      ),
    .rst_i          (rst_i      ),
    .scalar_req_i   (up_req     ),
    .scalar_valid_i (up_valid   ),
    .scalar_ready_o (up_ready   ),
    .acc_req_i      (flt_req    ),
    .acc_valid_i    (flt_valid  ),
    .acc_ready_o    (flt_ready  ),
    .mem_req_o      (mem_req_o  ),
    .mem_valid_o    (mem_valid_o),
    .mem_ready_i    (mem_ready_i)
  );

endmodule

/* bench/vsys_tb.sv */
/* Store path testbench
   Directed and random stores checked against a reference model */

`timescale 1ns/1ps

`include "vsys_cfg.svh"

module vsys_tb import vsys_pkg::*; ();

  localparam int unsigned TIMEOUT = 200;

  logic                    clk;
  logic                    rst;
  logic                    cons_en;
  narrow_req_t             scalar_req;
  logic                    scalar_valid;
  logic                    scalar_ready;
  wide_req_t               acc_req;
  logic                    acc_valid;
  logic                    acc_ready;
  sys_req_t                mem_req;
  logic                    mem_valid;
  logic                    mem_ready;
  logic [`VSYS_ADDR_W-1:0] inval_addr;
  logic                    inval_valid;
  logic                    inval_ready;

  sys_req_t                scalar_q[$];
  sys_req_t                acc_q[$];
  logic [`VSYS_ADDR_W-1:0] inval_q[$];
  logic                    line_vld;
  logic [`VSYS_ADDR_W-1:0] line_ref;
  logic                    rand_bp;
  logic                    alt_check;
  logic                    alt_seen;
  src_e                    last_src;
  int unsigned             inval_cnt;
  int unsigned             inval_base;

  vsys_top UUT (
    .clk_i          (clk         ),
    .rst_i          (rst         ),
    .cons_en_i      (cons_en     ),
    .scalar_req_i   (scalar_req  ),
    .scalar_valid_i (scalar_valid),
    .scalar_ready_o (scalar_ready),
    .acc_req_i      (acc_req     ),
    .acc_valid_i    (acc_valid   ),
    .acc_ready_o    (acc_ready   ),
    .mem_req_o      (mem_req     ),
    .mem_valid_o    (mem_valid   ),
    .mem_ready_i    (mem_ready   ),
    .inval_addr_o   (inval_addr  ),
    .inval_valid_o  (inval_valid ),
    .inval_ready_i  (inval_ready )
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic wide_req_t upsize_ref(input narrow_req_t req);
    wide_req_t res;
    res.addr = {req.addr[`VSYS_ADDR_W-1:3], 3'b000};
    // Bit 2 picks the upper half of the wide word
    if (req.addr[2]) begin
      res.data = {req.data, 32'h0};
      res.strb = {req.strb, 4'h0};
    end else begin
      res.data = {32'h0, req.data};
      res.strb = {4'h0, req.strb};
    end
    return res;
  endfunction

  // Also updates the remembered line
  function automatic logic inval_ref(input wide_req_t req, input logic en,
                                     output logic [`VSYS_ADDR_W-1:0] addr);
    logic [`VSYS_ADDR_W-1:0] line;
    logic                    due;
    line = req.addr & ~(`VSYS_ADDR_W'(`VSYS_LINE_BYTES - 1));
    due  = en && (req.strb != '0) && (!line_vld || line != line_ref);
    addr = line;
    if (due) begin
      line_vld = 1'b1;
      line_ref = line;
    end
    return due;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_sys_req(input sys_req_t exp, input sys_req_t act);
    if (act !== exp) begin
      $display("error at %0t: mem_req_o expected %h got %h", $time, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_inval(input logic [`VSYS_ADDR_W-1:0] exp,
                             input logic [`VSYS_ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("error at %0t: inval_addr_o expected %h got %h", $time, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int unsigned exp,
                             input int unsigned act);
    if (act != exp) begin
      $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  always @(posedge clk) begin : monitor
    logic [`VSYS_ADDR_W-1:0] exp_line;
    sys_req_t                exp_req;
    if (rst) begin
      line_vld = 1'b0;
    end else begin
      if (scalar_valid && scalar_ready) begin
        exp_req.req = upsize_ref(scalar_req);
        exp_req.src = SRC_SCALAR;
        scalar_q.push_back(exp_req);
      end
      if (acc_valid && acc_ready) begin
        if (inval_ref(acc_req, cons_en, exp_line)) begin
          inval_q.push_back(exp_line);
        end
        exp_req.req = acc_req;
        exp_req.src = SRC_ACCEL;
        acc_q.push_back(exp_req);
      end
      if (!cons_en) begin
        line_vld = 1'b0;
      end
      if (mem_valid && mem_ready) begin
        if ((mem_req.src == SRC_SCALAR && scalar_q.size() == 0) ||
            (mem_req.src == SRC_ACCEL && acc_q.size() == 0)) begin
          $display("System port sent a request that was never issued at %0t", $time);
          stop_with_failure();
        end else begin
          exp_req = (mem_req.src == SRC_SCALAR) ? scalar_q.pop_front() : acc_q.pop_front();
          check_sys_req(exp_req, mem_req);
          if (alt_check && alt_seen && mem_req.src == last_src) begin
            $display("error at %0t: mem_req_o.src expected %0d got %0d",
                     $time, !last_src, mem_req.src);
            stop_with_failure();
          end
          alt_seen = 1'b1;
          last_src = mem_req.src;
        end
      end
      if (inval_valid && inval_ready) begin
        if (inval_q.size() == 0) begin
          $display("Invalidation of %h was not expected at %0t", inval_addr, $time);
          stop_with_failure();
        end else begin
          check_inval(inval_q.pop_front(), inval_addr);
          inval_cnt++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rand_bp) begin
      mem_ready   = ($urandom % 3 != 0);
      inval_ready = ($urandom % 2 == 0);
    end
  end

  function automatic narrow_req_t rand_scalar();
    narrow_req_t r;
    r.addr = 32'h0000_1000 | ($urandom & 32'h0000_00fc);
    r.data = $urandom;
    r.strb = 4'($urandom);
    return r;
  endfunction

  function automatic wide_req_t rand_acc();
    wide_req_t r;
    r.addr = 32'h0000_2000 | ($urandom & 32'h0000_00f8);
    r.data = {$urandom, $urandom};
    r.strb = 8'($urandom);
    return r;
  endfunction

  // Valid stays high after acceptance until the next negedge
  task automatic send_scalar(input narrow_req_t req);
    int unsigned cnt;
    cnt = 0;
    @(negedge clk);
    scalar_req   = req;
    scalar_valid = 1'b1;
    @(posedge clk);
    while (!scalar_ready) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("Scalar store to %h was never accepted", req.addr);
        stop_with_failure();
      end
      @(posedge clk);
    end
  endtask

  task automatic send_acc(input wide_req_t req, input logic en);
    int unsigned cnt;
    cnt = 0;
    @(negedge clk);
    acc_req   = req;
    acc_valid = 1'b1;
    cons_en   = en;
    @(posedge clk);
    while (!acc_ready) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("Accelerator store to %h was never accepted", req.addr);
        stop_with_failure();
      end
      @(posedge clk);
    end
  endtask

  task automatic scalar_stream(input int n, input logic gaps);
    int i;
    for (i = 0; i < n; i++) begin
      if (gaps && ($urandom % 4 == 0)) begin
        @(negedge clk);
        scalar_valid = 1'b0;
      end
      send_scalar(rand_scalar());
    end
    @(negedge clk);
    scalar_valid = 1'b0;
  endtask

  // With gaps, consistency also toggles at random
  task automatic acc_stream(input int n, input logic gaps);
    int i;
    for (i = 0; i < n; i++) begin
      if (gaps && ($urandom % 4 == 0)) begin
        @(negedge clk);
        acc_valid = 1'b0;
      end
      send_acc(rand_acc(), gaps ? ($urandom % 4 != 0) : cons_en);
    end
    @(negedge clk);
    acc_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int unsigned cnt;
    cnt = 0;
    @(negedge clk);
    while (scalar_q.size() != 0 || acc_q.size() != 0 || inval_q.size() != 0) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        $display("Still missing %0d scalar, %0d accelerator requests and %0d invalidations",
                 scalar_q.size(), acc_q.size(), inval_q.size());
        stop_with_failure();
      end
      @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(84275));
    $timeformat(-9, 0, " ns", 0);
    clk          = 1'b0;
    rst          = 1'b1;
    cons_en      = 1'b0;
    scalar_req   = '0;
    scalar_valid = 1'b0;
    acc_req      = '0;
    acc_valid    = 1'b0;
    mem_ready    = 1'b1;
    inval_ready  = 1'b1;
    rand_bp      = 1'b0;
    alt_check    = 1'b0;
    alt_seen     = 1'b0;
    last_src     = SRC_SCALAR;
    inval_cnt    = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Both halves of the wide word, then random scalar stores
    send_scalar('{addr: 32'h0000_0100, data: 32'h1111_2222, strb: 4'hf});
    send_scalar('{addr: 32'h0000_0104, data: 32'h3333_4444, strb: 4'h3});
    scalar_stream(20, 1'b0);
    wait_drain();

    // Accelerator stores with consistency off
    acc_stream(20, 1'b0);
    wait_drain();

    // Same line, new line, then a consistency toggle
    inval_base = inval_cnt;
    send_acc('{addr: 32'h0000_3000, data: 64'h1, strb: 8'h0f}, 1'b1);
    send_acc('{addr: 32'h0000_3008, data: 64'h2, strb: 8'hf0}, 1'b1);
    send_acc('{addr: 32'h0000_3010, data: 64'h3, strb: 8'hff}, 1'b1);
    @(negedge clk);
    acc_valid = 1'b0;
    cons_en   = 1'b0;
    send_acc('{addr: 32'h0000_3018, data: 64'h4, strb: 8'h01}, 1'b1);
    @(negedge clk);
    acc_valid = 1'b0;
    wait_drain();
    check_count("inval_valid_o transfers", 3, inval_cnt - inval_base);

    // Both sources busy, no back-pressure
    @(negedge clk);
    cons_en   = 1'b0;
    alt_check = 1'b1;
    alt_seen  = 1'b0;
    fork
      scalar_stream(8, 1'b0);
      acc_stream(8, 1'b0);
    join
    wait_drain();
    alt_check = 1'b0;

    // Random traffic under random back-pressure
    rand_bp = 1'b1;
    fork
      scalar_stream(60, 1'b1);
      acc_stream(60, 1'b1);
    join
    rand_bp = 1'b0;
    @(negedge clk);
    mem_ready   = 1'b1;
    inval_ready = 1'b1;
    wait_drain();

    $display("All tests passed");
    $finish;
  end

endmodule

/* vsys.f */
+incdir+common
common/vsys_pkg.sv
verilog/pipe_reg.sv
verilog/store_upsizer.sv
verilog/inval_filter.sv
verilog/store_arbiter.sv
verilog/vsys_top.sv
bench/vsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the store path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vsys.f --top-module vsys_tb -o vsys_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vsys_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

exit 0
